/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_periph_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/periph_properties.sv */
/*
  Concurrent checks on bus timing and interrupt outputs, bound into the
  subsystem top level. fail_count is read by the testbench summary.
*/
`timescale 1ns/100ps

module periph_properties (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic msip_o,
  input logic timer_intr0_o,
  input logic timer_intr1_o
);

  int fail_count = 0;

  // Each accepted request answered exactly one cycle later
  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i && gnt_o) |=> rvalid_o)
    else begin
      $error("granted request not followed by rvalid");
      fail_count++;
    end

  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    !(req_i && gnt_o) |=> !rvalid_o)
    else begin
      $error("rvalid without a grant one cycle earlier");
      fail_count++;
    end

  // No back-pressure
  gnt_follows_req: assert property (@(posedge clk_i) gnt_o == req_i)
    else begin
      $error("grant differs from request");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (!msip_o && !timer_intr0_o && !timer_intr1_o))
    else begin
      $error("interrupt output high right after reset");
      fail_count++;
    end

endmodule

bind periph_subsystem periph_properties u_props (
  .clk_i, .rst_i, .req_i, .gnt_o, .rvalid_o, .msip_o, .timer_intr0_o, .timer_intr1_o
);

/* dv/tb_periph_subsystem.sv */
/*
  Testbench of the peripheral subsystem. Drives the core bus and the interrupt
  sources, checks readback and interrupt outputs, then prints a summary.
*/
`timescale 1ns/100ps

module tb_periph_subsystem;
  import periph_pkg::*;

  localparam int unsigned NUM_SRC = 8;
  // Whole run is about 100 cycles and the timer poll is the longest part
  localparam int MAX_CYCLES = 2000;

  logic               clk_i;
  logic               rst_i;
  logic               req_i;
  logic               we_i;
  addr_t              addr_i;
  data_t              wdata_i;
  strb_t              be_i;
  logic [NUM_SRC-1:0] irq_src_i;
  logic               gnt_o;
  logic               rvalid_o;
  data_t              rdata_o;
  logic               irq_o;
  logic               msip_o;
  logic               timer_intr0_o;
  logic               timer_intr1_o;

  int                 seed = 32'h3305;
  int                 cycles = 0;
  int                 errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 test_err_start;
  string              test_name;
  data_t              rd;
  data_t              wd;
  data_t              en;
  data_t              exp_claim;
  strb_t              be;
  logic [NUM_SRC-1:0] src;
  data_t              cmp0_sh;
  data_t              irq_en_sh;
  addr_t              b2b_addr[4];
  data_t              b2b_exp[4];

  periph_subsystem #(.NUM_IRQ_SRC(NUM_SRC)) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic addr_t reg_addr(periph_sel_t sel, reg_idx_t idx);
    return addr_t'({sel, 12'h000}) | addr_t'({idx, 2'b00});
  endfunction

  function automatic data_t be_mask(strb_t b);
    data_t m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = b[i] ? 8'hff : 8'h00;
    end
    return m;
  endfunction

  // Source n has ID n+1, the first enabled pending one counting up wins
  function automatic data_t expected_claim(logic [NUM_SRC-1:0] s, data_t e);
    data_t id;
    id = '0;
    for (int n = 0; n < NUM_SRC; n++) begin
      if (id == '0 && s[n] && e[n+1]) begin
        id = data_t'(n + 1);
      end
    end
    return id;
  endfunction

  task automatic check_val(data_t exp, data_t act);
    assert (act == exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_rvalid();
    while (!rvalid_o) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic bus_write(addr_t addr, data_t data, strb_t b);
    req_i = 1'b1;
    we_i = 1'b1;
    addr_i = addr;
    wdata_i = data;
    be_i = b;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    we_i = 1'b0;
    wait_rvalid();
  endtask

  task automatic bus_read(addr_t addr, output data_t data);
    req_i = 1'b1;
    we_i = 1'b0;
    addr_i = addr;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    wait_rvalid();
    data = rdata_o;
  endtask

  task automatic read_check(addr_t addr, data_t exp);
    data_t got;
    bus_read(addr, got);
    check_val(exp, got);
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors > test_err_start) begin
      tests_failed++;
      $display("%s: FAIL", test_name);
    end else begin
      $display("%s: PASS", test_name);
    end
  endtask

  initial begin
    rst_i = 1'b1;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    irq_src_i = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    begin_test("byte_enable_rw");
    cmp0_sh = '0;
    irq_en_sh = '0;
    repeat (4) begin
      wd = $random(seed);
      be = strb_t'($random(seed));
      bus_write(reg_addr(TIMER_IDX, TMR_CMP0), wd, be);
      cmp0_sh = (cmp0_sh & ~be_mask(be)) | (wd & be_mask(be));
      read_check(reg_addr(TIMER_IDX, TMR_CMP0), cmp0_sh);
      wd = $random(seed);
      be = strb_t'($random(seed));
      bus_write(reg_addr(IRQ_CTRL_IDX, IRQ_ENABLE), wd, be);
      irq_en_sh = (irq_en_sh & ~be_mask(be)) | (wd & be_mask(be));
      read_check(reg_addr(IRQ_CTRL_IDX, IRQ_ENABLE), irq_en_sh);
    end
    end_test();

    begin_test("unmapped_access");
    read_check(reg_addr(4'd5, TMR_CMP0), 32'h0);
    bus_write(reg_addr(4'd5, TMR_CMP0), 32'hffff_ffff, 4'hf);
    bus_write(reg_addr(4'd5, IRQ_ENABLE), 32'hffff_ffff, 4'hf);
    read_check(reg_addr(TIMER_IDX, TMR_CMP0), cmp0_sh);
    read_check(reg_addr(IRQ_CTRL_IDX, IRQ_ENABLE), irq_en_sh);
    end_test();

    begin_test("timer_expiry");
    bus_write(reg_addr(TIMER_IDX, TMR_PRESCALE), 32'd1, 4'hf);
    bus_write(reg_addr(TIMER_IDX, TMR_CMP0), 32'd10, 4'hf);
    bus_write(reg_addr(TIMER_IDX, TMR_CMP1), 32'd20, 4'hf);
    bus_write(reg_addr(TIMER_IDX, TMR_CTRL), 32'd1, 4'hf);
    rd = '0;
    while (rd < 32'd20) begin
      bus_read(reg_addr(TIMER_IDX, TMR_COUNT), rd);
    end
    check_val(32'd1, data_t'(timer_intr0_o));
    check_val(32'd1, data_t'(timer_intr1_o));
    bus_write(reg_addr(TIMER_IDX, TMR_STATUS), 32'd1, 4'hf);
    check_val(32'd0, data_t'(timer_intr0_o));
    check_val(32'd1, data_t'(timer_intr1_o));
    end_test();

    begin_test("irq_claim");
    repeat (6) begin
      src = NUM_SRC'($random(seed));
      en = $random(seed);
      irq_src_i = src;
      bus_write(reg_addr(IRQ_CTRL_IDX, IRQ_ENABLE), en, 4'hf);
      exp_claim = expected_claim(src, en);
      read_check(reg_addr(IRQ_CTRL_IDX, IRQ_CLAIM), exp_claim);
      check_val(data_t'(exp_claim != '0), data_t'(irq_o));
    end
    // Nothing enabled
    bus_write(reg_addr(IRQ_CTRL_IDX, IRQ_ENABLE), 32'h0, 4'hf);
    irq_en_sh = '0;
    read_check(reg_addr(IRQ_CTRL_IDX, IRQ_CLAIM), 32'h0);
    check_val(32'd0, data_t'(irq_o));
    irq_src_i = '0;
    end_test();

    begin_test("software_irq");
    bus_write(reg_addr(IRQ_CTRL_IDX, IRQ_MSIP), 32'd1, 4'hf);
    check_val(32'd1, data_t'(msip_o));
    bus_write(reg_addr(IRQ_CTRL_IDX, IRQ_MSIP), 32'd0, 4'hf);
    check_val(32'd0, data_t'(msip_o));
    end_test();

    begin_test("back_to_back");
    b2b_addr[0] = reg_addr(TIMER_IDX, TMR_CMP0);
    b2b_addr[1] = reg_addr(TIMER_IDX, TMR_CMP1);
    b2b_addr[2] = reg_addr(TIMER_IDX, TMR_PRESCALE);
    b2b_addr[3] = reg_addr(IRQ_CTRL_IDX, IRQ_ENABLE);
    b2b_exp[0] = 32'd10;
    b2b_exp[1] = 32'd20;
    b2b_exp[2] = 32'd1;
    b2b_exp[3] = irq_en_sh;
    req_i = 1'b1;
    we_i = 1'b0;
    addr_i = b2b_addr[0];
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      #1;
      check_val(32'd1, data_t'(rvalid_o));
      check_val(b2b_exp[i], rdata_o);
      if (i < 3) begin
        addr_i = b2b_addr[i+1];
      end else begin
        req_i = 1'b0;
      end
    end
    @(posedge clk_i);
    #1;
    end_test();

    $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion errors: %0d",
             tests_run, tests_failed, errors, UUT.u_props.fail_count);
    if (tests_failed == 0 && errors == 0 && UUT.u_props.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
src/periph_pkg.sv
src/bus_reg_bridge.sv
src/periph_decoder.sv
src/timer_regs.sv
src/timer_core.sv
src/irq_ctrl.sv
src/periph_subsystem.sv
dv/periph_properties.sv
dv/tb_periph_subsystem.sv

/* src/bus_reg_bridge.sv */
/*
  Core request/grant/rvalid bus to single-cycle register bus.
  Grants every request and answers one cycle later with rvalid and read data.
*/
`timescale 1ns/100ps

module bus_reg_bridge (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             req_i,
  input  logic             we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::strb_t be_i,
  input  periph_pkg::data_t reg_rdata_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output periph_pkg::data_t rdata_o,
  output logic             reg_valid_o,
  output logic             reg_we_o,
  output periph_pkg::addr_t reg_addr_o,
  output periph_pkg::data_t reg_wdata_o,
  output periph_pkg::data_t reg_wmask_o
);
  import periph_pkg::*;

  logic  rvalid_q;
  data_t rdata_q;

  // Registers never stall, so every request is granted at once
  assign gnt_o = req_i;

  assign reg_valid_o = req_i & gnt_o;
  assign reg_we_o    = we_i;
  assign reg_addr_o  = addr_i;
  assign reg_wdata_o = wdata_i;

  // Byte enables to bit mask
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      reg_wmask_o[8*b +: 8] = {8{be_i[b]}};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_valid_o;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (reg_valid_o) begin
      rdata_q <= we_i ? '0 : reg_rdata_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

/* src/irq_ctrl.sv */
/*
  Interrupt controller with level sources, an enable mask, a claim ID and a
  software interrupt bit. irq_src_i[n] is interrupt ID n+1; ID 0 is reserved.
*/
`timescale 1ns/100ps

module irq_ctrl #(
  parameter int unsigned NUM_IRQ_SRC = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  logic                   we_i,
  input  periph_pkg::addr_t       addr_i,
  input  periph_pkg::data_t       wdata_i,
  input  periph_pkg::data_t       wmask_i,
  input  logic [NUM_IRQ_SRC-1:0] irq_src_i,
  output periph_pkg::data_t       rdata_o,
  output logic                   irq_o,
  output logic                   msip_o
);
  import periph_pkg::*;

  reg_idx_t idx;
  logic     wr_en;
  data_t    enable_q;
  data_t    pending;
  data_t    active;
  irq_id_t  claim_id;
  logic     irq_q;
  logic     msip_q;

  assign idx   = addr_i[REG_IDX_LSB +: $bits(reg_idx_t)];
  assign wr_en = valid_i & we_i;

  // Bit 0 stays low for the reserved ID
  assign pending = data_t'({irq_src_i, 1'b0});
  assign active  = pending & enable_q;

  // Lowest active ID wins
  always_comb begin
    claim_id = '0;
    for (int i = NUM_IRQ_SRC; i >= 1; i--) begin
      if (active[i]) begin
        claim_id = irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= '0;
      msip_q   <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      if (wr_en && idx == IRQ_ENABLE) begin
        enable_q <= masked_write(enable_q, wdata_i, wmask_i);
      end
      if (wr_en && idx == IRQ_MSIP && wmask_i[0]) begin
        msip_q <= wdata_i[0];
      end
      irq_q <= |active;
    end
  end

  always_comb begin
    case (idx)
      IRQ_ENABLE:  rdata_o = enable_q;
      IRQ_PENDING: rdata_o = pending;
      IRQ_CLAIM:   rdata_o = data_t'(claim_id);
      IRQ_MSIP:    rdata_o = data_t'(msip_q);
      default:     rdata_o = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule

/* src/periph_decoder.sv */
/*
  Address decoder of the register bus. Picks the peripheral from the upper
  address bits, raises its valid and returns its read data.
*/
`timescale 1ns/100ps

module periph_decoder (
  input  logic             reg_valid_i,
  input  periph_pkg::addr_t reg_addr_i,
  input  periph_pkg::data_t irq_rdata_i,
  input  periph_pkg::data_t tmr_rdata_i,
  output logic             irq_valid_o,
  output logic             tmr_valid_o,
  output periph_pkg::data_t reg_rdata_o
);
  import periph_pkg::*;

  periph_sel_t sel;

  assign sel = reg_addr_i[SEL_LSB +: $bits(periph_sel_t)];

  // At most one valid, none for an unmapped index
  assign irq_valid_o = reg_valid_i && (sel == IRQ_CTRL_IDX);
  assign tmr_valid_o = reg_valid_i && (sel == TIMER_IDX);

  always_comb begin
    case (sel)
      IRQ_CTRL_IDX: reg_rdata_o = irq_rdata_i;
      TIMER_IDX:    reg_rdata_o = tmr_rdata_i;
      default:      reg_rdata_o = '0;
    endcase
  end

endmodule

/* src/periph_pkg.sv */
/*
  Shared types, peripheral indices and register offsets of the peripheral
  subsystem. Modules import it inside the body and use scoped names on ports.
*/
package periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  periph_sel_t;
  typedef logic [4:0]  irq_id_t;
  // Word index inside one peripheral
  typedef logic [2:0]  reg_idx_t;

  // Address fields
  localparam int unsigned SEL_LSB     = 12;
  localparam int unsigned REG_IDX_LSB = 2;

  localparam periph_sel_t IRQ_CTRL_IDX = 4'd0;
  localparam periph_sel_t TIMER_IDX    = 4'd1;

  // Timer word offsets
  localparam reg_idx_t TMR_CTRL     = 3'd0;
  localparam reg_idx_t TMR_PRESCALE = 3'd1;
  localparam reg_idx_t TMR_COUNT    = 3'd2;
  localparam reg_idx_t TMR_CMP0     = 3'd3;
  localparam reg_idx_t TMR_CMP1     = 3'd4;
  localparam reg_idx_t TMR_STATUS   = 3'd5;

  // Interrupt controller word offsets
  localparam reg_idx_t IRQ_ENABLE  = 3'd0;
  localparam reg_idx_t IRQ_PENDING = 3'd1;
  localparam reg_idx_t IRQ_CLAIM   = 3'd2;
  localparam reg_idx_t IRQ_MSIP    = 3'd3;

  // Bit-masked register update
  function automatic data_t masked_write(data_t old_val, data_t wdata, data_t wmask);
    return (old_val & ~wmask) | (wdata & wmask);
  endfunction

endpackage

/* src/periph_subsystem.sv */
/*
  Peripheral subsystem top level. Core bus in, interrupt controller and
  timer behind a bridge and an address decoder.
*/
`timescale 1ns/100ps

module periph_subsystem #(
  parameter int unsigned NUM_IRQ_SRC = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  periph_pkg::addr_t       addr_i,
  input  periph_pkg::data_t       wdata_i,
  input  periph_pkg::strb_t       be_i,
  input  logic [NUM_IRQ_SRC-1:0] irq_src_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output periph_pkg::data_t       rdata_o,
  output logic                   irq_o,
  output logic                   msip_o,
  output logic                   timer_intr0_o,
  output logic                   timer_intr1_o
);
  import periph_pkg::*;

  logic  reg_valid, reg_we;
  addr_t reg_addr;
  data_t reg_wdata, reg_wmask, reg_rdata;
  logic  irq_valid, tmr_valid;
  data_t irq_rdata, tmr_rdata;

  // Timer config and status
  logic  tmr_enable, match0, match1;
  data_t tmr_prescale, tmr_cmp0, tmr_cmp1, tmr_count;

  bus_reg_bridge u_bridge (
    .clk_i, .rst_i, .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .reg_rdata_i(reg_rdata),
    .gnt_o, .rvalid_o, .rdata_o,
    .reg_valid_o(reg_valid), .reg_we_o(reg_we), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_wmask_o(reg_wmask)
  );

  periph_decoder u_decoder (
    .reg_valid_i(reg_valid), .reg_addr_i(reg_addr),
    .irq_rdata_i(irq_rdata), .tmr_rdata_i(tmr_rdata),
    .irq_valid_o(irq_valid), .tmr_valid_o(tmr_valid), .reg_rdata_o(reg_rdata)
  );

  irq_ctrl #(.NUM_IRQ_SRC(NUM_IRQ_SRC)) u_irq_ctrl (
    .clk_i, .rst_i, .valid_i(irq_valid), .we_i(reg_we), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .wmask_i(reg_wmask), .irq_src_i,
    .rdata_o(irq_rdata), .irq_o, .msip_o
  );

  timer_regs u_timer_regs (
    .clk_i, .rst_i, .valid_i(tmr_valid), .we_i(reg_we), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .wmask_i(reg_wmask), .count_i(tmr_count),
    .match0_i(match0), .match1_i(match1), .rdata_o(tmr_rdata),
    .enable_o(tmr_enable), .prescale_o(tmr_prescale), .cmp0_o(tmr_cmp0),
    .cmp1_o(tmr_cmp1), .intr0_o(timer_intr0_o), .intr1_o(timer_intr1_o)
  );

  timer_core u_timer_core (
    .clk_i, .rst_i, .enable_i(tmr_enable), .prescale_i(tmr_prescale),
    .cmp0_i(tmr_cmp0), .cmp1_i(tmr_cmp1), .count_o(tmr_count),
    .match0_o(match0), .match1_o(match1)
  );

endmodule

/* src/timer_core.sv */
/*
  Timer counting logic. A prescaler divides the clock for a free-running
  counter; two comparators pulse when the counter steps onto their value.
*/
`timescale 1ns/100ps

module timer_core (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             enable_i,
  input  periph_pkg::data_t prescale_i,
  input  periph_pkg::data_t cmp0_i,
  input  periph_pkg::data_t cmp1_i,
  output periph_pkg::data_t count_o,
  output logic             match0_o,
  output logic             match1_o
);
  import periph_pkg::*;

  data_t presc_q;
  data_t count_q;
  data_t count_next;
  logic  tick;

  // >= so a prescale lowered mid-count still ticks
  assign tick       = enable_i && (presc_q >= prescale_i);
  assign count_next = count_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      presc_q <= '0;
      count_q <= '0;
    end else if (enable_i) begin
      if (tick) begin
        presc_q <= '0;
        count_q <= count_next;
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

  assign match0_o = tick && (count_next == cmp0_i);
  assign match1_o = tick && (count_next == cmp1_i);
  assign count_o  = count_q;

endmodule

/* src/timer_regs.sv */
/*
  Timer register block. Holds enable, prescale and compare values for the
  counter, and the sticky expired flags that drive the timer interrupts.
*/
`timescale 1ns/100ps

module timer_regs (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic             we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::data_t wmask_i,
  input  periph_pkg::data_t count_i,
  input  logic             match0_i,
  input  logic             match1_i,
  output periph_pkg::data_t rdata_o,
  output logic             enable_o,
  output periph_pkg::data_t prescale_o,
  output periph_pkg::data_t cmp0_o,
  output periph_pkg::data_t cmp1_o,
  output logic             intr0_o,
  output logic             intr1_o
);
  import periph_pkg::*;

  reg_idx_t   idx;
  logic       wr_en;
  logic       enable_q;
  data_t      prescale_q;
  data_t      cmp0_q;
  data_t      cmp1_q;
  logic [1:0] expired_q;
  logic [1:0] clr;

  assign idx   = addr_i[REG_IDX_LSB +: $bits(reg_idx_t)];
  assign wr_en = valid_i & we_i;

  // Write 1 to clear, only in enabled bytes
  assign clr = (wr_en && idx == TMR_STATUS) ? (wdata_i[1:0] & wmask_i[1:0]) : 2'b00;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q   <= 1'b0;
      prescale_q <= '0;
      cmp0_q     <= '0;
      cmp1_q     <= '0;
      expired_q  <= 2'b00;
    end else begin
      if (wr_en) begin
        case (idx)
          TMR_CTRL:     if (wmask_i[0]) enable_q <= wdata_i[0];
          TMR_PRESCALE: prescale_q <= masked_write(prescale_q, wdata_i, wmask_i);
          TMR_CMP0:     cmp0_q <= masked_write(cmp0_q, wdata_i, wmask_i);
          TMR_CMP1:     cmp1_q <= masked_write(cmp1_q, wdata_i, wmask_i);
          default: ;
        endcase
      end
      // A match in the same cycle beats the clear
      expired_q <= (expired_q & ~clr) | {match1_i, match0_i};
    end
  end

  always_comb begin
    case (idx)
      TMR_CTRL:     rdata_o = data_t'(enable_q);
      TMR_PRESCALE: rdata_o = prescale_q;
      TMR_COUNT:    rdata_o = count_i;
      TMR_CMP0:     rdata_o = cmp0_q;
      TMR_CMP1:     rdata_o = cmp1_q;
      TMR_STATUS:   rdata_o = data_t'(expired_q);
      default:      rdata_o = '0;
    endcase
  end

  assign enable_o   = enable_q;
  assign prescale_o = prescale_q;
  assign cmp0_o     = cmp0_q;
  assign cmp1_o     = cmp1_q;
  assign intr0_o    = expired_q[0];
  assign intr1_o    = expired_q[1];

endmodule
